//--- verification/paddle_vectors.txt
// paddle_l paddle_r glitch expected_left_base expected_right_base, all hex
// glitch 1 pulses the listed levels briefly, then the buttons return to their held levels
1 0 0 200 000
1 1 0 400 200
0 0 1 600 400
1 1 0 400 600
0 0 0 400 600
1 1 1 400 600
1 1 0 200 400
1 0 0 000 400
1 1 0 200 200
0 1 0 200 000
0 1 0 200 200
1 0 0 400 200

//--- project.f
logic/laser_pkg.sv
logic/point_if.sv
logic/paddle_debounce.sv
logic/paddle_scene_gen.sv
logic/point_fifo.sv
logic/dac_spi_serializer.sv
logic/laser_projector.sv
verification/laser_projector_assertions.sv
verification/laser_projector_tb.sv

//--- Bender.yml
package:
  name: laser_projector

sources:
  - files:
      - logic/laser_pkg.sv
      - logic/point_if.sv
      - logic/paddle_debounce.sv
      - logic/paddle_scene_gen.sv
      - logic/point_fifo.sv
      - logic/dac_spi_serializer.sv
      - logic/laser_projector.sv
  - target: test
    files:
      - verification/laser_projector_assertions.sv
      - verification/laser_projector_tb.sv

//--- verification/laser_projector_tb.sv
`timescale 1ns/1ps

module laser_projector_tb import laser_pkg::*; ();

    localparam int DEB       = 8;
    localparam int PPP       = 4;
    localparam int FRAME_PTS = 2 * PPP;
    localparam int SDIV      = 2;
    localparam int FRAMES    = 12;  // lines in the vector file
    localparam int LIMIT     = FRAMES * FRAME_PTS * (2 * (32 * SDIV + 2) + 2) * 2
                             + FRAMES * (3 * DEB + 50) + 400;

    logic             clk = 1'b0;
    logic             rst;
    logic             paddle_l;
    logic             paddle_r;
    logic             frame_sync;
    logic             dac_sclk;
    logic             dac_mosi;
    logic             dac_csn;
    logic             dac_latchn;
    logic [RGB_W-1:0] laser_rgb;

    logic [COORD_W-1:0] vec [FRAMES * 5];  // l, r, glitch, left base, right base
    logic [34:0]        cap_q [$];         // {word a, word b, rgb} per latched point
    int                 errors = 0;
    integer             seed = 32'h2dec_27e4;
    bit                 started = 1'b0;    // first frame strobe given

    // spi capture state
    logic             sclk_q = 1'b0;
    logic             csn_q = 1'b1;
    logic             latchn_q = 1'b1;
    logic [15:0]      shift;
    logic [15:0]      word_a;
    logic [15:0]      word_b;
    int               nbits = 0;
    int               nwords = 0;
    logic [RGB_W-1:0] rgb_now = '0;

    laser_projector #(
        .DEBOUNCE_CYCLES(DEB), .POINTS_PER_PADDLE(PPP), .FIFO_DEPTH(4), .SCLK_DIV(SDIV)
    ) uut (
        .clk(clk), .rst(rst), .paddle_l(paddle_l), .paddle_r(paddle_r),
        .frame_sync(frame_sync), .dac_sclk(dac_sclk), .dac_mosi(dac_mosi),
        .dac_csn(dac_csn), .dac_latchn(dac_latchn), .laser_rgb(laser_rgb)
    );

    always #5 clk = ~clk;

    task automatic tick(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error %s = %h, expected %h", name, got, exp);
        end
    endtask

    //////////////////////////////
    // spi capture, sampled mid-cycle
    //////////////////////////////
    always @(negedge clk) begin
        if (!rst) begin
            if (!dac_csn && csn_q && !started) begin
                errors++;
                $display("csn fell before the first frame strobe");
            end
            if (!dac_csn && dac_sclk && !sclk_q) begin
                shift = {shift[14:0], dac_mosi};  // msb arrives first
                nbits++;
            end
            if (dac_csn && !csn_q) begin
                if (nbits != 16) begin
                    errors++;
                    $display("dac transfer had %0d sclk rises instead of 16", nbits);
                end
                if (nwords == 0) word_a = shift;
                else word_b = shift;
                nwords++;
                nbits = 0;
            end
            if (!dac_latchn && latchn_q) begin
                if (nwords != 2) begin
                    errors++;
                    $display("latch pulse came after %0d words instead of 2", nwords);
                end
                rgb_now = laser_rgb;
                cap_q.push_back({word_a, word_b, laser_rgb});
                nwords = 0;
            end
            if (!dac_latchn && !latchn_q) begin
                errors++;
                $display("latchn stayed low for more than one clock");
            end
            check_value("laser_rgb", laser_rgb, rgb_now);  // holds between latches
        end
        sclk_q   = dac_sclk;
        csn_q    = dac_csn;
        latchn_q = dac_latchn;
    end

    initial begin
        logic               prev_l;
        logic               prev_r;
        logic               right;
        logic [34:0]        got;
        logic [COORD_W-1:0] ex_x;
        logic [COORD_W-1:0] ex_y;
        logic [RGB_W-1:0]   ex_rgb;
        int                 k;
        int                 asrt;
        $readmemh("verification/paddle_vectors.txt", vec);
        rst        = 1'b1;
        paddle_l   = 1'b0;
        paddle_r   = 1'b0;
        frame_sync = 1'b0;
        prev_l     = 1'b0;
        prev_r     = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_value("dac_csn", dac_csn, 1'b1);
        check_value("dac_latchn", dac_latchn, 1'b1);
        check_value("dac_sclk", dac_sclk, 1'b0);
        check_value("laser_rgb", laser_rgb, '0);
        tick(20);  // idle, capture watches for a stray csn fall

        for (int f = 0; f < FRAMES; f++) begin
            if (vec[f * 5 + 2][0]) begin
                paddle_l = vec[f * 5][0];  // short glitch, then back to held level
                paddle_r = vec[f * 5 + 1][0];
                tick(3);
                paddle_l = prev_l;
                paddle_r = prev_r;
            end else begin
                paddle_l = vec[f * 5][0];
                paddle_r = vec[f * 5 + 1][0];
                prev_l   = paddle_l;
                prev_r   = paddle_r;
            end
            tick(3 * DEB);
            started    = 1'b1;
            frame_sync = 1'b1;
            tick(1);
            frame_sync = 1'b0;
            if (f % 2 == 1) begin
                tick(4);
                frame_sync = 1'b1;  // mid-frame strobe, must be ignored
                tick(1);
                frame_sync = 1'b0;
            end
            while (cap_q.size() < FRAME_PTS) tick(1);
            for (int p = 0; p < FRAME_PTS; p++) begin
                got    = cap_q.pop_front();
                right  = (p >= PPP);
                k      = right ? p - PPP : p;
                ex_x   = right ? RIGHT_X : LEFT_X;
                ex_y   = vec[f * 5 + (right ? 4 : 3)] + k * PADDLE_PITCH;
                ex_rgb = right ? RIGHT_RGB : LEFT_RGB;
                check_value($sformatf("dac_mosi word a (frame %0d point %0d)", f, p),
                            got[34:19], {4'b0011, ex_x});
                check_value($sformatf("dac_mosi word b (frame %0d point %0d)", f, p),
                            got[18:3], {4'b1011, ex_y});
                check_value($sformatf("laser_rgb (frame %0d point %0d)", f, p),
                            got[2:0], ex_rgb);
            end
            tick($unsigned($random(seed)) % 32);
        end

        tick(300);
        if (cap_q.size() != 0) begin
            errors++;
            $display("%0d extra points were sent after the last frame", cap_q.size());
        end
        asrt = uut.fifo.fifo_chk.fails + uut.dac.ser_chk.fails;
        $display("errors: %0d checks, %0d assertions", errors, asrt);
        if (errors == 0 && asrt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("run did not finish within %0d clocks", LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- verification/laser_projector_assertions.sv
`timescale 1ns/1ps

module laser_projector_assertions #(
    parameter int DEPTH = 4
) (
    input logic clk,
    input logic rst,
    input logic push,
    input logic full,
    input logic pop,
    input logic empty,
    input logic csn,
    input logic latchn,
    input logic sclk
);

    int fails = 0;  // failure tally
    int level = 0;  // entries held, tracked from the strobes

    always @(posedge clk) begin
        if (rst) begin
            level <= 0;
        end else if (push && !pop) begin
            level <= level + 1;
        end else if (pop && !push) begin
            level <= level - 1;
        end
    end

    a_push_full: assert property (@(posedge clk) disable iff (rst) push |-> (level < DEPTH))
        else begin
            $error("push while fifo full");
            fails++;
        end

    a_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else begin
            $error("pop while fifo empty");
            fails++;
        end

    a_latch_csn: assert property (@(posedge clk) disable iff (rst) !latchn |-> csn)
        else begin
            $error("latchn low during a transfer");
            fails++;
        end

    a_sclk_idle: assert property (@(posedge clk) disable iff (rst) csn |-> !sclk)
        else begin
            $error("sclk high while csn high");
            fails++;
        end

endmodule

bind point_fifo laser_projector_assertions #(.DEPTH(FIFO_DEPTH)) fifo_chk (
    .clk(clk), .rst(rst), .push(wr.push), .full(wr.full), .pop(rd.pop), .empty(rd.empty),
    .csn(1'b1), .latchn(1'b1), .sclk(1'b0)
);

bind dac_spi_serializer laser_projector_assertions ser_chk (
    .clk(clk), .rst(rst), .push(1'b0), .full(1'b0), .pop(1'b0), .empty(1'b0),
    .csn(csn), .latchn(latchn), .sclk(sclk)
);

//--- logic/laser_projector.sv
`timescale 1ns/1ps

module laser_projector import laser_pkg::*; #(
    parameter int DEBOUNCE_CYCLES   = 8,
    parameter int POINTS_PER_PADDLE = 4,
    parameter int FIFO_DEPTH        = 4,
    parameter int SCLK_DIV          = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             paddle_l,
    input  logic             paddle_r,
    input  logic             frame_sync,
    output logic             dac_sclk,
    output logic             dac_mosi,
    output logic             dac_csn,
    output logic             dac_latchn,
    output logic [RGB_W-1:0] laser_rgb
);

    logic clean_l;  // debounced left button
    logic clean_r;

    point_if scene_pts ();
    point_if dac_pts ();

    //////////////////////////////
    // buttons
    //////////////////////////////
    paddle_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) db_l (
        .clk(clk), .rst(rst), .noisy(paddle_l), .clean(clean_l)
    );

    paddle_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) db_r (
        .clk(clk), .rst(rst), .noisy(paddle_r), .clean(clean_r)
    );

    //////////////////////////////
    // point path
    //////////////////////////////
    paddle_scene_gen #(.POINTS_PER_PADDLE(POINTS_PER_PADDLE)) scene (
        .clk(clk), .rst(rst), .frame_sync(frame_sync),
        .paddle_l(clean_l), .paddle_r(clean_r), .pts(scene_pts.producer)
    );

    point_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo (
        .clk(clk), .rst(rst), .wr(scene_pts.fifo_in), .rd(dac_pts.fifo_out)
    );

    dac_spi_serializer #(.SCLK_DIV(SCLK_DIV)) dac (
        .clk(clk), .rst(rst), .pts(dac_pts.consumer),
        .sclk(dac_sclk), .mosi(dac_mosi), .csn(dac_csn),
        .latchn(dac_latchn), .laser_rgb(laser_rgb)
    );

endmodule

//--- logic/dac_spi_serializer.sv
`timescale 1ns/1ps

module dac_spi_serializer import laser_pkg::*; #(
    parameter int SCLK_DIV = 2
) (
    input  logic             clk,
    input  logic             rst,
    point_if.consumer        pts,
    output logic             sclk,
    output logic             mosi,
    output logic             csn,
    output logic             latchn,
    output logic [RGB_W-1:0] laser_rgb
);

    localparam int DIV_W = $clog2(SCLK_DIV + 1);
    localparam int BIT_W = $clog2(DAC_WORD_W);

    localparam logic [2:0] IDLE    = 3'd0;
    localparam logic [2:0] SHIFT   = 3'd1;
    localparam logic [2:0] GAP     = 3'd2;  // csn high between the two words
    localparam logic [2:0] LATCH   = 3'd3;
    localparam logic [2:0] RELEASE = 3'd4;

    logic [2:0]            state;
    logic                  second;     // channel b word on the wire
    logic [DIV_W-1:0]      div;
    logic [BIT_W-1:0]      bit_cnt;
    logic [DAC_WORD_W-1:0] shreg;
    dac_word_u             word_next;

    // x goes out on channel a from idle, y on channel b after the gap
    always_comb begin
        word_next.fields.ch_b     = (state == GAP);
        word_next.fields.buffered = 1'b0;
        word_next.fields.gain     = 1'b1;
        word_next.fields.shdn_n   = 1'b1;
        word_next.fields.data     = (state == GAP) ? pts.y : pts.x;
    end

    assign pts.pop = (state == LATCH);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            second    <= 1'b0;
            div       <= '0;
            bit_cnt   <= '0;
            sclk      <= 1'b0;
            mosi      <= 1'b0;
            csn       <= 1'b1;
            latchn    <= 1'b1;
            laser_rgb <= '0;
        end else begin
            case (state)
                IDLE, GAP: begin
                    if (state == GAP || !pts.empty) begin
                        shreg   <= word_next.raw;
                        mosi    <= word_next.raw[DAC_WORD_W-1];  // msb first
                        csn     <= 1'b0;
                        second  <= (state == GAP);
                        div     <= '0;
                        bit_cnt <= '0;
                        state   <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (div == DIV_W'(SCLK_DIV - 1)) begin
                        div  <= '0;
                        sclk <= ~sclk;
                        if (sclk) begin  // falling edge
                            if (bit_cnt == BIT_W'(DAC_WORD_W - 1)) begin
                                csn   <= 1'b1;
                                state <= second ? LATCH : GAP;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                                shreg   <= {shreg[DAC_WORD_W-2:0], 1'b0};
                                mosi    <= shreg[DAC_WORD_W-2];
                            end
                        end
                    end else begin
                        div <= div + 1'b1;
                    end
                end
                LATCH: begin
                    latchn    <= 1'b0;     // both channels update together
                    laser_rgb <= pts.rgb;
                    state     <= RELEASE;
                end
                default: begin
                    latchn <= 1'b1;
                    state  <= IDLE;
                end
            endcase
        end
    end

endmodule

//--- logic/point_fifo.sv
`timescale 1ns/1ps

module point_fifo import laser_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    point_if.fifo_in  wr,
    point_if.fifo_out rd
);

    localparam int ENTRY_W = 2 * COORD_W + RGB_W;
    localparam int PTR_W   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W   = $clog2(FIFO_DEPTH + 1);

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];  // {x, y, rgb}
    logic [PTR_W-1:0]   wptr;
    logic [PTR_W-1:0]   rptr;
    logic [CNT_W-1:0]   count;
    logic               do_wr;
    logic               do_rd;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_wr    = wr.push && !wr.full;
    assign do_rd    = rd.pop && !rd.empty;
    assign wr.full  = (count == CNT_W'(FIFO_DEPTH));
    assign rd.empty = (count == '0);
    assign {rd.x, rd.y, rd.rgb} = mem[rptr];  // head always on show

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wptr] <= {wr.x, wr.y, wr.rgb};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_wr) wptr <= next_ptr(wptr);
            if (do_rd) rptr <= next_ptr(rptr);
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or both
            endcase
        end
    end

endmodule

//--- logic/paddle_scene_gen.sv
`timescale 1ns/1ps

module paddle_scene_gen import laser_pkg::*; #(
    parameter int POINTS_PER_PADDLE = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      frame_sync,
    input  logic      paddle_l,
    input  logic      paddle_r,
    point_if.producer pts
);

    localparam int FRAME_PTS = 2 * POINTS_PER_PADDLE;
    localparam int IDX_W     = (FRAME_PTS > 1) ? $clog2(FRAME_PTS) : 1;

    logic               busy;       // frame in progress
    logic [IDX_W-1:0]   idx;        // point being offered
    logic [IDX_W-1:0]   k;
    logic               right_side;
    logic [COORD_W-1:0] base_l;
    logic [COORD_W-1:0] base_r;
    logic               up_l;
    logic               up_r;

    // returns {up, base} after one frame of button input
    function automatic logic [COORD_W:0] step_paddle(input logic               held,
                                                     input logic               up,
                                                     input logic [COORD_W-1:0] base);
        logic [COORD_W:0] sum;
        logic [COORD_W:0] result;
        sum = {1'b0, base} + {1'b0, PADDLE_STEP};
        if (!held) begin
            result = {up, base};
        end else if (up && (sum > {1'b0, PADDLE_TOP})) begin
            result = {1'b0, base - PADDLE_STEP};  // bounce off the top
        end else if (up) begin
            result = {1'b1, sum[COORD_W-1:0]};
        end else if (base < PADDLE_STEP) begin
            result = {1'b1, sum[COORD_W-1:0]};  // bounce off the bottom
        end else begin
            result = {1'b0, base - PADDLE_STEP};
        end
        return result;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            idx    <= '0;
            base_l <= '0;
            base_r <= '0;
            up_l   <= 1'b1;
            up_r   <= 1'b1;
        end else if (!busy) begin
            if (frame_sync) begin
                {up_l, base_l} <= step_paddle(paddle_l, up_l, base_l);
                {up_r, base_r} <= step_paddle(paddle_r, up_r, base_r);
                busy <= 1'b1;
                idx  <= '0;
            end
        end else if (!pts.full) begin
            if (idx == IDX_W'(FRAME_PTS - 1)) begin
                busy <= 1'b0;
            end
            idx <= idx + 1'b1;
        end
    end

    // left paddle points first, then right
    assign right_side = (idx >= IDX_W'(POINTS_PER_PADDLE));
    assign k          = right_side ? idx - IDX_W'(POINTS_PER_PADDLE) : idx;

    assign pts.push = busy && !pts.full;
    assign pts.x    = right_side ? RIGHT_X : LEFT_X;
    assign pts.y    = (right_side ? base_r : base_l) + COORD_W'(k) * PADDLE_PITCH;
    assign pts.rgb  = right_side ? RIGHT_RGB : LEFT_RGB;

endmodule

//--- logic/paddle_debounce.sv
`timescale 1ns/1ps

module paddle_debounce #(
    parameter int DEBOUNCE_CYCLES = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic noisy,
    output logic clean
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [1:0]       sync;   // two flop synchronizer
    logic             last;   // level being timed
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync  <= '0;
            last  <= 1'b0;
            cnt   <= '0;
            clean <= 1'b0;
        end else begin
            sync <= {sync[0], noisy};
            if (sync[1] != last) begin
                last <= sync[1];  // level moved, restart timing
                cnt  <= '0;
            end else if (cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                clean <= last;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

//--- logic/point_if.sv
`timescale 1ns/1ps

// one laser point plus its fifo handshake levels
interface point_if import laser_pkg::*; ();

    logic               push;
    logic               pop;
    logic               full;
    logic               empty;
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    logic [RGB_W-1:0]   rgb;

    modport producer (output push, x, y, rgb, input full);
    modport fifo_in  (input push, x, y, rgb, output full);
    modport fifo_out (output x, y, rgb, empty, input pop);
    modport consumer (input x, y, rgb, empty, output pop);

endinterface

//--- logic/laser_pkg.sv
package laser_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////
    localparam int COORD_W    = 12;  // dac resolution
    localparam int RGB_W      = 3;
    localparam int DAC_WORD_W = 16;

    //////////////////////////////
    // scene constants
    //////////////////////////////
    localparam logic [COORD_W-1:0] LEFT_X       = 12'd256;
    localparam logic [COORD_W-1:0] RIGHT_X      = 12'd3840;
    localparam logic [RGB_W-1:0]   LEFT_RGB     = 3'b100;  // red
    localparam logic [RGB_W-1:0]   RIGHT_RGB    = 3'b001;  // blue
    localparam logic [COORD_W-1:0] PADDLE_PITCH = 12'd256;
    localparam logic [COORD_W-1:0] PADDLE_STEP  = 12'd512;
    localparam logic [COORD_W-1:0] PADDLE_TOP   = 12'd1536; // highest base y

    // one dac transfer, seen as command fields or as a plain shift word
    typedef union packed {
        struct packed {
            logic               ch_b;      // 0 selects channel a
            logic               buffered;  // vref input buffer
            logic               gain;      // 1 = 1x output gain
            logic               shdn_n;    // 0 shuts the channel down
            logic [COORD_W-1:0] data;
        } fields;
        logic [DAC_WORD_W-1:0] raw;
    } dac_word_u;

endpackage
